// ==== riscv_pkg.sv ====
////////////////////////////////////////////////////////////
// RV32I shared definitions: data width, major opcodes,
// ALU operations, immediate formats, write-back sources
////////////////////////////////////////////////////////////

package riscv_pkg;

	// Data and address width
	parameter int XLEN = 32;

	// Major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011,
		OP_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_e;

	// Immediate layouts of the base ISA
	typedef enum logic [2:0] {
		IMM_I,
		IMM_S,
		IMM_B,
		IMM_U,
		IMM_J
	} imm_fmt_e;

	// Register write-back source
	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_PC4
	} wb_sel_e;

endpackage

// ==== alu.sv ====
////////////////////////////////////////////////////////////
// ALU with shifts and compares, plus the branch condition
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module alu (
	input  riscv_pkg::alu_op_e         i_op,
	input  logic [riscv_pkg::XLEN-1:0] i_a,
	input  logic [riscv_pkg::XLEN-1:0] i_b,
	input  logic [2:0]                i_funct3,
	output logic [riscv_pkg::XLEN-1:0] o_result,
	output logic                      o_branch_taken
);

	logic [4:0] shamt;
	logic       eq;
	logic       lt;
	logic       ltu;

	assign shamt = i_b[4:0];
	assign eq    = (i_a == i_b);
	assign lt    = ($signed(i_a) < $signed(i_b));
	assign ltu   = (i_a < i_b);

	always_comb begin
		case (i_op)
			riscv_pkg::ALU_SUB:  o_result = i_a - i_b;
			riscv_pkg::ALU_SLL:  o_result = i_a << shamt;
			riscv_pkg::ALU_SLT:  o_result = {31'b0, lt};
			riscv_pkg::ALU_SLTU: o_result = {31'b0, ltu};
			riscv_pkg::ALU_XOR:  o_result = i_a ^ i_b;
			riscv_pkg::ALU_SRL:  o_result = i_a >> shamt;
			riscv_pkg::ALU_SRA:  o_result = $unsigned($signed(i_a) >>> shamt);
			riscv_pkg::ALU_OR:   o_result = i_a | i_b;
			riscv_pkg::ALU_AND:  o_result = i_a & i_b;
			default:             o_result = i_a + i_b;
		endcase
	end

	// BEQ, BNE, BLT, BGE, BLTU, BGEU
	always_comb begin
		case (i_funct3)
			3'b000:  o_branch_taken = eq;
			3'b001:  o_branch_taken = !eq;
			3'b100:  o_branch_taken = lt;
			3'b101:  o_branch_taken = !lt;
			3'b110:  o_branch_taken = ltu;
			3'b111:  o_branch_taken = !ltu;
			default: o_branch_taken = 1'b0;
		endcase
	end

endmodule

// ==== imm_gen.sv ====
////////////////////////////////////////////////////////////
// Immediate generator for the I, S, B, U and J formats
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module imm_gen (
	input  logic [riscv_pkg::XLEN-1:0] i_instr,
	input  riscv_pkg::imm_fmt_e        i_fmt,
	output logic [riscv_pkg::XLEN-1:0] o_imm
);

	logic sign;

	assign sign = i_instr[31];

	// B and J come out in byte units with bit 0 clear
	always_comb begin
		case (i_fmt)
			riscv_pkg::IMM_S:
				o_imm = {{20{sign}}, i_instr[31:25], i_instr[11:7]};
			riscv_pkg::IMM_B:
				o_imm = {{19{sign}}, sign, i_instr[7], i_instr[30:25],
					i_instr[11:8], 1'b0};
			riscv_pkg::IMM_U:
				o_imm = {i_instr[31:12], 12'b0};
			riscv_pkg::IMM_J:
				o_imm = {{11{sign}}, sign, i_instr[19:12], i_instr[20],
					i_instr[30:21], 1'b0};
			default:
				o_imm = {{20{sign}}, i_instr[31:20]};
		endcase
	end

endmodule

// ==== reg_file.sv ====
////////////////////////////////////////////////////////////
// 32 x XLEN register file, two reads and one write, x0 = 0
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module reg_file (
	input  logic                      i_clk,
	input  logic [4:0]                i_rs1,
	input  logic [4:0]                i_rs2,
	output logic [riscv_pkg::XLEN-1:0] o_rd1,
	output logic [riscv_pkg::XLEN-1:0] o_rd2,
	input  logic                      i_wen,
	input  logic [4:0]                i_rd,
	input  logic [riscv_pkg::XLEN-1:0] i_wdata
);

	// x0 has no storage
	logic [riscv_pkg::XLEN-1:0] regs [1:31];

	always_ff @(posedge i_clk) begin
		if (i_wen && i_rd != 5'd0)
			regs[i_rd] <= i_wdata;
	end

	assign o_rd1 = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
	assign o_rd2 = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

	// Written value shows on read port 1 one cycle later, x0 stays zero
	a_write_read: assert property (@(posedge i_clk)
		($past(i_wen) && i_rs1 == $past(i_rd)) |->
		(o_rd1 == ((i_rs1 == 5'd0) ? '0 : $past(i_wdata))))
		else $error("register write not visible on the next read");

endmodule

// ==== main_control.sv ====
////////////////////////////////////////////////////////////
// Instruction decoder: opcode, funct3 and funct7 to
// datapath control levels and the ALU operation
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module main_control (
	input  logic [riscv_pkg::XLEN-1:0] i_instr,
	output riscv_pkg::alu_op_e         o_alu_op,
	output logic [1:0]                o_src_a,
	output logic                      o_src_b,
	output riscv_pkg::imm_fmt_e        o_imm_fmt,
	output riscv_pkg::wb_sel_e         o_wb_sel,
	output logic                      o_reg_wen,
	output logic                      o_branch,
	output logic                      o_jal,
	output logic                      o_jalr,
	output logic                      o_mem_ren,
	output logic                      o_mem_wen,
	output logic                      o_ebreak
);

	riscv_pkg::opcode_e opcode;
	riscv_pkg::alu_op_e arith_op;
	logic [2:0] funct3;
	logic [6:0] funct7;

	assign opcode = riscv_pkg::opcode_e'(i_instr[6:0]);
	assign funct3 = i_instr[14:12];
	assign funct7 = i_instr[31:25];

	// Register-register and register-immediate operation
	always_comb begin
		case (funct3)
			3'b000: arith_op = (opcode == riscv_pkg::OP_REG && funct7[5]) ?
				riscv_pkg::ALU_SUB : riscv_pkg::ALU_ADD;
			3'b001: arith_op = riscv_pkg::ALU_SLL;
			3'b010: arith_op = riscv_pkg::ALU_SLT;
			3'b011: arith_op = riscv_pkg::ALU_SLTU;
			3'b100: arith_op = riscv_pkg::ALU_XOR;
			3'b101: arith_op = funct7[5] ? riscv_pkg::ALU_SRA : riscv_pkg::ALU_SRL;
			3'b110: arith_op = riscv_pkg::ALU_OR;
			default: arith_op = riscv_pkg::ALU_AND;
		endcase
	end

	always_comb begin
		// No-op unless the opcode says otherwise
		o_alu_op  = riscv_pkg::ALU_ADD;
		o_src_a   = 2'b00;
		o_src_b   = 1'b0;
		o_imm_fmt = riscv_pkg::IMM_I;
		o_wb_sel  = riscv_pkg::WB_ALU;
		o_reg_wen = 1'b0;
		o_branch  = 1'b0;
		o_jal     = 1'b0;
		o_jalr    = 1'b0;
		o_mem_ren = 1'b0;
		o_mem_wen = 1'b0;
		o_ebreak  = 1'b0;
		case (opcode)
			riscv_pkg::OP_LUI: begin
				o_src_a   = 2'b10;
				o_src_b   = 1'b1;
				o_imm_fmt = riscv_pkg::IMM_U;
				o_reg_wen = 1'b1;
			end
			riscv_pkg::OP_AUIPC: begin
				o_src_a   = 2'b01;
				o_src_b   = 1'b1;
				o_imm_fmt = riscv_pkg::IMM_U;
				o_reg_wen = 1'b1;
			end
			riscv_pkg::OP_JAL: begin
				o_imm_fmt = riscv_pkg::IMM_J;
				o_wb_sel  = riscv_pkg::WB_PC4;
				o_reg_wen = 1'b1;
				o_jal     = 1'b1;
			end
			riscv_pkg::OP_JALR: begin
				o_src_b   = 1'b1;
				o_wb_sel  = riscv_pkg::WB_PC4;
				o_reg_wen = 1'b1;
				o_jalr    = 1'b1;
			end
			riscv_pkg::OP_BRANCH: begin
				o_alu_op  = riscv_pkg::ALU_SUB;
				o_imm_fmt = riscv_pkg::IMM_B;
				o_branch  = 1'b1;
			end
			riscv_pkg::OP_LOAD: begin
				o_src_b   = 1'b1;
				o_wb_sel  = riscv_pkg::WB_MEM;
				o_reg_wen = 1'b1;
				o_mem_ren = 1'b1;
			end
			riscv_pkg::OP_STORE: begin
				o_src_b   = 1'b1;
				o_imm_fmt = riscv_pkg::IMM_S;
				o_mem_wen = 1'b1;
			end
			riscv_pkg::OP_IMM: begin
				o_alu_op  = arith_op;
				o_src_b   = 1'b1;
				o_reg_wen = 1'b1;
			end
			riscv_pkg::OP_REG: begin
				o_alu_op  = arith_op;
				o_reg_wen = 1'b1;
			end
			// Only EBREAK among the system encodings
			riscv_pkg::OP_SYSTEM: o_ebreak = (i_instr[31:20] == 12'h001) &&
				(funct3 == 3'b000);
			default: ;
		endcase
	end

endmodule

// ==== load_store_unit.sv ====
////////////////////////////////////////////////////////////
// Load/store unit: data-bus request, byte lanes, stall
// until ready, load alignment and extension
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module load_store_unit (
	input  logic                      i_clk,
	input  logic                      i_rst,
	input  logic                      i_ren,
	input  logic                      i_wen,
	input  logic [2:0]                i_funct3,
	input  logic [riscv_pkg::XLEN-1:0] i_addr,
	input  logic [riscv_pkg::XLEN-1:0] i_store_data,
	output logic [riscv_pkg::XLEN-1:0] o_load_data,
	output logic                      o_stall,
	input  logic                      i_dm_ready,
	input  logic [riscv_pkg::XLEN-1:0] i_dm_rdata,
	output logic [riscv_pkg::XLEN-1:0] o_dm_addr,
	output logic [riscv_pkg::XLEN-1:0] o_dm_wdata,
	output logic [3:0]                o_dm_wstrb,
	output logic                      o_dm_wen,
	output logic                      o_dm_ren
);

	logic                      req;
	logic [4:0]                lane_shift;
	logic [riscv_pkg::XLEN-1:0] lane_data;
	logic [7:0]                ld_byte;
	logic [15:0]               ld_half;

	// Request is a level straight from the decoded instruction
	assign req      = i_ren | i_wen;
	assign o_stall  = req & ~i_dm_ready;
	assign o_dm_ren = i_ren;
	assign o_dm_wen = i_wen;

	// Word-aligned bus address
	assign o_dm_addr = {i_addr[riscv_pkg::XLEN-1:2], 2'b00};

	// Store lanes, data replicated so any strobe sees the right byte
	always_comb begin
		case (i_funct3[1:0])
			2'b00: begin
				o_dm_wdata = {4{i_store_data[7:0]}};
				o_dm_wstrb = 4'b0001 << i_addr[1:0];
			end
			2'b01: begin
				o_dm_wdata = {2{i_store_data[15:0]}};
				o_dm_wstrb = i_addr[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				o_dm_wdata = i_store_data;
				o_dm_wstrb = 4'b1111;
			end
		endcase
		if (!i_wen)
			o_dm_wstrb = 4'b0000;
	end

	// Bring the addressed lane down to bit 0
	assign lane_shift = {i_addr[1:0], 3'b000};
	assign lane_data  = i_dm_rdata >> lane_shift;
	assign ld_byte    = lane_data[7:0];
	assign ld_half    = lane_data[15:0];

	// funct3[2] selects zero extension
	always_comb begin
		case (i_funct3)
			3'b000:  o_load_data = {{24{ld_byte[7]}}, ld_byte};
			3'b001:  o_load_data = {{16{ld_half[15]}}, ld_half};
			3'b100:  o_load_data = {24'b0, ld_byte};
			3'b101:  o_load_data = {16'b0, ld_half};
			default: o_load_data = i_dm_rdata;
		endcase
	end

	// Bus holds still while the memory is not ready
	a_req_stable: assert property (@(posedge i_clk) disable iff (!i_rst)
		(req && !i_dm_ready) |=> ($stable(o_dm_addr) && $stable(o_dm_wdata) &&
		$stable(o_dm_wstrb) && $stable(o_dm_wen) && $stable(o_dm_ren)))
		else $error("data bus changed during a wait cycle");

endmodule

// ==== core_top.sv ====
////////////////////////////////////////////////////////////
// Single-cycle RV32I core: PC, next-PC selection, operand
// and write-back muxes around the decode and execute units
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module core_top #(
	parameter logic [riscv_pkg::XLEN-1:0] RESET_PC = '0
) (
	input  logic                      i_clk,
	input  logic                      i_rst,
	output logic [riscv_pkg::XLEN-1:0] o_im_addr,
	input  logic [riscv_pkg::XLEN-1:0] i_im_instr,
	input  logic                      i_dm_ready,
	input  logic [riscv_pkg::XLEN-1:0] i_dm_rdata,
	output logic [riscv_pkg::XLEN-1:0] o_dm_addr,
	output logic [riscv_pkg::XLEN-1:0] o_dm_wdata,
	output logic [3:0]                o_dm_wstrb,
	output logic                      o_dm_wen,
	output logic                      o_dm_ren,
	output logic                      o_halted
);

	logic [riscv_pkg::XLEN-1:0] pc_q;
	logic [riscv_pkg::XLEN-1:0] pc_plus4;
	logic [riscv_pkg::XLEN-1:0] pc_next;
	logic                      halted_q;

	riscv_pkg::alu_op_e  alu_op;
	riscv_pkg::imm_fmt_e imm_fmt;
	riscv_pkg::wb_sel_e  wb_sel;
	logic [1:0] src_a;
	logic       src_b;
	logic       reg_wen;
	logic       branch;
	logic       jal;
	logic       jalr;
	logic       mem_ren;
	logic       mem_wen;
	logic       ebreak;

	logic [riscv_pkg::XLEN-1:0] rd1;
	logic [riscv_pkg::XLEN-1:0] rd2;
	logic [riscv_pkg::XLEN-1:0] imm;
	logic [riscv_pkg::XLEN-1:0] alu_a;
	logic [riscv_pkg::XLEN-1:0] alu_b;
	logic [riscv_pkg::XLEN-1:0] alu_result;
	logic [riscv_pkg::XLEN-1:0] load_data;
	logic [riscv_pkg::XLEN-1:0] wb_data;
	logic                      branch_taken;
	logic                      stall;

	assign o_im_addr = pc_q;
	assign o_halted  = halted_q;
	assign pc_plus4  = pc_q + 32'd4;

	// PC freezes during a data stall and once halted
	always_ff @(posedge i_clk) begin
		if (!i_rst) begin
			pc_q     <= RESET_PC;
			halted_q <= 1'b0;
		end else begin
			if (!halted_q && !stall && !ebreak)
				pc_q <= pc_next;
			if (ebreak)
				halted_q <= 1'b1;
		end
	end

	always_comb begin
		if (jalr)
			pc_next = {alu_result[riscv_pkg::XLEN-1:1], 1'b0};
		else if (jal || (branch && branch_taken))
			pc_next = pc_q + imm;
		else
			pc_next = pc_plus4;
	end

	// src_a[1] selects zero, src_a[0] selects the PC
	assign alu_a = src_a[1] ? '0 : (src_a[0] ? pc_q : rd1);
	assign alu_b = src_b ? imm : rd2;

	always_comb begin
		case (wb_sel)
			riscv_pkg::WB_MEM: wb_data = load_data;
			riscv_pkg::WB_PC4: wb_data = pc_plus4;
			default:           wb_data = alu_result;
		endcase
	end

	main_control u_main_control (
		.i_instr   (i_im_instr),
		.o_alu_op  (alu_op),
		.o_src_a   (src_a),
		.o_src_b   (src_b),
		.o_imm_fmt (imm_fmt),
		.o_wb_sel  (wb_sel),
		.o_reg_wen (reg_wen),
		.o_branch  (branch),
		.o_jal     (jal),
		.o_jalr    (jalr),
		.o_mem_ren (mem_ren),
		.o_mem_wen (mem_wen),
		.o_ebreak  (ebreak)
	);

	reg_file u_reg_file (
		.i_clk   (i_clk),
		.i_rs1   (i_im_instr[19:15]),
		.i_rs2   (i_im_instr[24:20]),
		.o_rd1   (rd1),
		.o_rd2   (rd2),
		.i_wen   (reg_wen && !stall && !halted_q),
		.i_rd    (i_im_instr[11:7]),
		.i_wdata (wb_data)
	);

	imm_gen u_imm_gen (
		.i_instr (i_im_instr),
		.i_fmt   (imm_fmt),
		.o_imm   (imm)
	);

	alu u_alu (
		.i_op           (alu_op),
		.i_a            (alu_a),
		.i_b            (alu_b),
		.i_funct3       (i_im_instr[14:12]),
		.o_result       (alu_result),
		.o_branch_taken (branch_taken)
	);

	// No new requests after halt
	load_store_unit u_lsu (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_ren        (mem_ren && !halted_q),
		.i_wen        (mem_wen && !halted_q),
		.i_funct3     (i_im_instr[14:12]),
		.i_addr       (alu_result),
		.i_store_data (rd2),
		.o_load_data  (load_data),
		.o_stall      (stall),
		.i_dm_ready   (i_dm_ready),
		.i_dm_rdata   (i_dm_rdata),
		.o_dm_addr    (o_dm_addr),
		.o_dm_wdata   (o_dm_wdata),
		.o_dm_wstrb   (o_dm_wstrb),
		.o_dm_wen     (o_dm_wen),
		.o_dm_ren     (o_dm_ren)
	);

endmodule

// ==== tb_memory.sv ====
////////////////////////////////////////////////////////////
// Instruction ROM and data RAM model, random ready delay
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_memory (
	input  logic        i_clk,
	input  logic        i_rst,
	input  logic [31:0] i_im_addr,
	output logic [31:0] o_im_instr,
	input  logic [31:0] i_dm_addr,
	input  logic [31:0] i_dm_wdata,
	input  logic [3:0]  i_dm_wstrb,
	input  logic        i_dm_wen,
	input  logic        i_dm_ren,
	output logic        o_dm_ready,
	output logic [31:0] o_dm_rdata
);

	// Filled by the testbench top
	logic [31:0] rom [0:127];
	logic [31:0] ram [0:63];
	logic [31:0] rom_off;
	logic [15:0] lfsr;
	logic [1:0]  wait_left;
	logic        waiting;
	logic        done_last;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	initial begin
		lfsr = 16'd43241;
		o_dm_ready = 1'b0;
		waiting = 1'b0;
		wait_left = 2'd0;
		for (int i = 0; i < 64; i++)
			ram[i] = 32'hC0DE0000 | (32'(i) * 32'h00010101);
		ram[32] = 32'h80F192A3;
	end

	// Anything outside the program reads as a NOP
	assign rom_off    = i_im_addr - 32'h100;
	assign o_im_instr = (rom_off < 32'd512) ? rom[rom_off[8:2]] : 32'h00000013;
	assign o_dm_rdata = ram[i_dm_addr[7:2]];

	always @(posedge i_clk) begin
		if (i_dm_wen && o_dm_ready) begin
			for (int b = 0; b < 4; b++)
				if (i_dm_wstrb[b])
					ram[i_dm_addr[7:2]][8*b +: 8] <= i_dm_wdata[8*b +: 8];
		end
	end

	// 0 to 3 wait cycles per request, two LFSR bits each
	always @(negedge i_clk) begin
		done_last = o_dm_ready;
		o_dm_ready = 1'b0;
		if (!i_rst) begin
			waiting = 1'b0;
		end else if (i_dm_wen || i_dm_ren) begin
			if (!waiting || done_last) begin
				wait_left[1] = lfsr[15];
				lfsr = lfsr_step(lfsr);
				wait_left[0] = lfsr[15];
				lfsr = lfsr_step(lfsr);
				waiting = 1'b1;
			end else begin
				wait_left = wait_left - 2'd1;
			end
			o_dm_ready = (wait_left == 2'd0);
		end else begin
			waiting = 1'b0;
		end
	end

endmodule

// ==== tb_core.sv ====
////////////////////////////////////////////////////////////
// Testbench for the RV32I core: fixed program, memory model,
// store checks against a hand-computed table
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_core;

	localparam int NPROG  = 75;
	localparam int NSTORE = 32;
	// About 67 instructions at up to 4 cycles each plus margin
	localparam int LIMIT  = 800;

	// Hand-assembled program at 0x100
	localparam logic [31:0] PROG [0:NPROG-1] = '{
		32'h00500093, 32'hFFD00113, 32'h002081B3, 32'h00302023,
		32'h40208233, 32'h00402223, 32'h0020F2B3, 32'h00502423,
		32'h0020E333, 32'h00602623, 32'h0020C3B3, 32'h00702823,
		32'h00112433, 32'h001134B3, 32'h00802A23, 32'h00902C23,
		32'h00111533, 32'h001155B3, 32'h40115633, 32'h00A02E23,
		32'h02B02023, 32'h02C02223, 32'h123456B7, 32'h00001717,
		32'h00700013, 32'h02D02423, 32'h02E02623, 32'h02002823,
		// Loads from the preset word at 0x80
		32'h08100783, 32'h08304803, 32'h08201883, 32'h08005903,
		32'h08002983, 32'h02F02A23, 32'h03002C23, 32'h03102E23,
		32'h05202023, 32'h05302223,
		// SB at each offset then SH low and high
		32'h05300423, 32'h053004A3, 32'h05300523, 32'h053005A3,
		32'h05301623, 32'h05301723,
		// Branch pairs where taken skips a bad store and not-taken hits a marker
		32'h00108463, 32'h04202A23, 32'h00208463, 32'h04102823,
		32'h00209463, 32'h04202A23, 32'h00109463, 32'h04102823,
		32'h00114463, 32'h04202A23, 32'h0020C463, 32'h04102823,
		32'h0020D463, 32'h04202A23, 32'h00115463, 32'h04102823,
		32'h0020E463, 32'h04202A23, 32'h00116463, 32'h04102823,
		32'h00117463, 32'h04202A23, 32'h0020F463, 32'h04102823,
		// JAL, JALR, link stores, EBREAK
		32'h00800A6F, 32'h04202A23, 32'h05402C23, 32'h010A0AE7,
		32'h04202A23, 32'h05502E23, 32'h00100073
	};

	localparam logic [31:0] EXP_ADDR [0:NSTORE-1] = '{
		32'h00, 32'h04, 32'h08, 32'h0C, 32'h10, 32'h14, 32'h18, 32'h1C,
		32'h20, 32'h24, 32'h28, 32'h2C, 32'h30, 32'h34, 32'h38, 32'h3C,
		32'h40, 32'h44, 32'h48, 32'h48, 32'h48, 32'h48, 32'h4C, 32'h4C,
		32'h50, 32'h50, 32'h50, 32'h50, 32'h50, 32'h50, 32'h58, 32'h5C
	};

	localparam logic [3:0] EXP_STRB [0:NSTORE-1] = '{
		4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF,
		4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF,
		4'hF, 4'hF, 4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hC,
		4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF, 4'hF
	};

	localparam logic [31:0] EXP_DATA [0:NSTORE-1] = '{
		32'h00000002, 32'h00000008, 32'h00000005, 32'hFFFFFFFD,
		32'hFFFFFFF8, 32'h00000001, 32'h00000000, 32'hFFFFFFA0,
		32'h07FFFFFF, 32'hFFFFFFFF, 32'h12345000, 32'h0000115C,
		32'h00000000, 32'hFFFFFF92, 32'h00000080, 32'hFFFF80F1,
		32'h000092A3, 32'h80F192A3, 32'hA3A3A3A3, 32'hA3A3A3A3,
		32'hA3A3A3A3, 32'hA3A3A3A3, 32'h92A392A3, 32'h92A392A3,
		32'h00000005, 32'h00000005, 32'h00000005, 32'h00000005,
		32'h00000005, 32'h00000005, 32'h00000214, 32'h00000220
	};

	logic        i_clk;
	logic        i_rst;
	logic [31:0] im_addr;
	logic [31:0] im_instr;
	logic        dm_ready;
	logic [31:0] dm_rdata;
	logic [31:0] dm_addr;
	logic [31:0] dm_wdata;
	logic [3:0]  dm_wstrb;
	logic        dm_wen;
	logic        dm_ren;
	logic        halted;
	logic [5:0]  store_idx;
	int          cycles;

	core_top #(.RESET_PC(32'h100)) UUT (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.o_im_addr  (im_addr),
		.i_im_instr (im_instr),
		.i_dm_ready (dm_ready),
		.i_dm_rdata (dm_rdata),
		.o_dm_addr  (dm_addr),
		.o_dm_wdata (dm_wdata),
		.o_dm_wstrb (dm_wstrb),
		.o_dm_wen   (dm_wen),
		.o_dm_ren   (dm_ren),
		.o_halted   (halted)
	);

	tb_memory u_mem (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_im_addr  (im_addr),
		.o_im_instr (im_instr),
		.i_dm_addr  (dm_addr),
		.i_dm_wdata (dm_wdata),
		.i_dm_wstrb (dm_wstrb),
		.i_dm_wen   (dm_wen),
		.i_dm_ren   (dm_ren),
		.o_dm_ready (dm_ready),
		.o_dm_rdata (dm_rdata)
	);

	function automatic string group_name(input logic [5:0] idx);
		if (idx < 6'd13)
			return "alu";
		else if (idx < 6'd18)
			return "load";
		else if (idx < 6'd24)
			return "byte_half_store";
		else if (idx < 6'd30)
			return "branch";
		return "jump";
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic report_store(input logic [5:0] idx, input logic [31:0] addr,
		input logic [3:0] strb, input logic [31:0] data);
		$display("Error %s store %0d: expected addr %h strb %h data %h, actual addr %h strb %h data %h",
			group_name(idx), idx, EXP_ADDR[idx[4:0]], EXP_STRB[idx[4:0]],
			EXP_DATA[idx[4:0]], addr, strb, data);
		$display("Test FAILED");
		$fatal(1);
	endtask

	initial begin
		i_clk = 1'b0;
		forever #20 i_clk = ~i_clk;
	end

	// Completed writes, counted at the edge where they retire
	always @(posedge i_clk) begin
		if (!i_rst)
			store_idx <= '0;
		else if (dm_wen && dm_ready)
			store_idx <= store_idx + 6'd1;
	end

	a_reset_state: assert property (@(posedge i_clk) $rose(i_rst) |->
		(im_addr == 32'h100 && !dm_wen && !dm_ren && !halted))
		else fail_run($sformatf(
			"Error reset: expected addr %h wen/ren/halt 000, actual %h %b%b%b",
			32'h100, $sampled(im_addr), $sampled(dm_wen), $sampled(dm_ren),
			$sampled(halted)));

	a_store_count: assert property (@(posedge i_clk) disable iff (!i_rst)
		(dm_wen && dm_ready) |-> (store_idx < 6'(NSTORE)))
		else fail_run("Store seen after the last expected one");

	a_store_value: assert property (@(posedge i_clk) disable iff (!i_rst)
		(dm_wen && dm_ready && store_idx < 6'(NSTORE)) |->
		(dm_addr == EXP_ADDR[store_idx[4:0]] && dm_wstrb == EXP_STRB[store_idx[4:0]] &&
		dm_wdata == EXP_DATA[store_idx[4:0]]))
		else report_store($sampled(store_idx), $sampled(dm_addr), $sampled(dm_wstrb),
			$sampled(dm_wdata));

	// Everything the core drives holds during a wait cycle
	a_hold: assert property (@(posedge i_clk) disable iff (!i_rst)
		((dm_wen || dm_ren) && !dm_ready) |=> ($stable(im_addr) && $stable(dm_addr) &&
		$stable(dm_wdata) && $stable(dm_wstrb) && $stable(dm_wen) && $stable(dm_ren)))
		else fail_run("Core outputs changed while the data memory was not ready");

	initial begin
		i_rst = 1'b0;
		cycles = 0;
		for (int i = 0; i < 128; i++)
			u_mem.rom[i] = (i < NPROG) ? PROG[i] : 32'h00000013;
		repeat (16) @(negedge i_clk);
		i_rst = 1'b1;
		while (!halted && cycles < LIMIT) begin
			@(negedge i_clk);
			cycles++;
		end
		if (!halted) begin
			fail_run("Timeout, core did not halt");
		end else if (store_idx != 6'(NSTORE)) begin
			fail_run("Core halted before all expected stores were seen");
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

// ==== filelist.f ====
riscv_pkg.sv
alu.sv
imm_gen.sv
reg_file.sv
main_control.sv
load_store_unit.sv
core_top.sv
tb_memory.sv
tb_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_core -f filelist.f -o tb_core_sim
out=$(./obj_dir/tb_core_sim) || true
echo "$out"
if echo "$out" | grep -qx "Test OK"; then
	exit 0
else
	exit 1
fi
